// File: bench/game_patterns.txt
# cmd dir goal | preset rows 0..3 | expected rows 0..3 | score draw (all hex)
# rows give cells col0..col3; cmd R restart, P preset, M move
R 0 b 0000 0000 0000 0000 1100 0000 0000 0000 000 0
P 0 b 1122 0000 0000 0000 1122 0000 0000 0000 000 0
M 1 b 0000 0000 0000 0000 2310 0000 0000 0000 002 0
P 0 b 1122 0000 0000 0000 1122 0000 0000 0000 002 0
M 8 b 0000 0000 0000 0000 1023 0000 0000 0000 004 0
P 0 b 1000 1000 2000 2000 1000 1000 2000 2000 004 0
M 2 b 0000 0000 0000 0000 2100 3000 0000 0000 006 0
P 0 b 1000 1000 2000 2000 1000 1000 2000 2000 006 0
M 4 b 0000 0000 0000 0000 1000 0000 2000 3000 008 0
P 0 b 1230 2100 0000 0000 1230 2100 0000 0000 008 0
M 1 b 0000 0000 0000 0000 1230 2100 0000 0000 008 0
M 3 b 0000 0000 0000 0000 1230 2100 0000 0000 008 0
P 0 4 3300 0000 0000 0000 3300 0000 0000 0000 008 0
M 1 4 0000 0000 0000 0000 4100 0000 0000 0000 009 1
M 8 4 0000 0000 0000 0000 4100 0000 0000 0000 009 1
R 0 b 0000 0000 0000 0000 1100 0000 0000 0000 000 0
P 0 b 1212 2121 1212 2121 1212 2121 1212 2121 000 2
R 0 b 0000 0000 0000 0000 1100 0000 0000 0000 000 0
P 0 b 0212 1212 2121 1212 0212 1212 2121 1212 000 0
M 1 b 0000 0000 0000 0000 2121 1212 2121 1212 000 2
M 2 b 0000 0000 0000 0000 2121 1212 2121 1212 000 2

// File: bench/game_checks.svh
`ifndef GAME_CHECKS_SVH
`define GAME_CHECKS_SVH

// compares the whole board at once and prints it as packed hex
task automatic check_board(input string name, input board_t got, input board_t exp);
    if (got !== exp) begin
        abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_score(input string name, input score_t got, input score_t exp);
    if (got !== exp) begin
        abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_draw(
    input string       name,
    input draw_state_t got,
    input draw_state_t exp
);
    if (got !== exp) begin
        abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
endtask

`endif

// File: bench/game_tb.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module game_tb;
    import board_pkg::*;
    import control_pkg::*;

    localparam string PATTERN_FILE = "bench/game_patterns.txt";
    localparam int HOLD_CYCLES = 3;
    // clear, two spawns and a check before input_ready
    localparam int START_CYCLES = 4;
    localparam int CYCLES_PER_LINE = 30;

    typedef struct packed {
        logic [7:0]  cmd;
        logic [3:0]  key;
        tile_t       goal;
        board_t      preset;
        board_t      exp_board;
        score_t      exp_score;
        draw_state_t exp_draw;
    } pattern_t;

    logic        clk;
    logic        reset;
    logic        restart;
    tile_t       goal;
    logic [3:0]  dir;
    logic        preset;
    board_t      preset_board;
    board_t      board;
    score_t      score;
    draw_state_t draw_state;
    logic        input_ready;

    pattern_t patterns[$];
    // board the last finished command should have left behind
    board_t   last_exp_board;
    int       cycle_count = 0;
    int       timeout_limit = 100;
    // seed for random stimulus
    integer   seed = 32'hf34;

    `include "game_checks.svh"

    game_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .restart      (restart),
        .goal         (goal),
        .dir          (dir),
        .preset       (preset),
        .preset_board (preset_board),
        .board        (board),
        .score        (score),
        .draw_state   (draw_state),
        .input_ready  (input_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            abort_run($sformatf("timeout after %0d cycles, input_ready never returned",
                cycle_count));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // rows in the file list cells col0..col3 from the left
    function automatic board_t words_to_board(input logic [15:0] w0, w1, w2, w3);
        logic [63:0] flat;
        board_t      b;
        flat = {w0, w1, w2, w3};
        for (int r = 0; r < `GAME_GRID; r++) begin
            for (int c = 0; c < `GAME_GRID; c++) begin
                b[r][c] = flat[63 - 16*r - `GAME_TILE_BITS*c -: `GAME_TILE_BITS];
            end
        end
        return b;
    endfunction

    task automatic read_patterns();
        int          fd;
        int          code;
        logic [7:0]  cmd;
        logic [3:0]  key;
        logic [3:0]  goal_word;
        logic [15:0] p0, p1, p2, p3;
        logic [15:0] e0, e1, e2, e3;
        logic [15:0] score_word;
        logic [3:0]  draw_word;
        logic [8*200-1:0] skip_buf;
        pattern_t    p;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the pattern file");
        end else begin
            code = $fscanf(fd, " %c", cmd);
            while (code == 1) begin
                if (cmd == "#") begin
                    code = $fgets(skip_buf, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", key, goal_word,
                        p0, p1, p2, p3, e0, e1, e2, e3, score_word, draw_word);
                    if (code != 12) begin
                        abort_run("malformed line in the pattern file");
                    end
                    p.cmd = cmd;
                    p.key = key;
                    p.goal = tile_t'(goal_word);
                    p.preset = words_to_board(p0, p1, p2, p3);
                    p.exp_board = words_to_board(e0, e1, e2, e3);
                    p.exp_score = score_t'(score_word);
                    p.exp_draw = draw_state_t'(draw_word[1:0]);
                    patterns.push_back(p);
                end
                code = $fscanf(fd, " %c", cmd);
            end
            $fclose(fd);
        end
    endtask

    // stops on input_ready or on a finished game
    task automatic wait_for_ready(output int waited);
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!input_ready && draw_state == DRAW_ACTIVE);
    endtask

    task automatic send_restart();
        int waited;
        restart = 1'b1;
        @(posedge clk);
        #1;
        restart = 1'b0;
        wait_for_ready(waited);
        if (waited != START_CYCLES) begin
            abort_run($sformatf("FAILED input_ready delay: got %h expected %h",
                waited, START_CYCLES));
        end
    endtask

    task automatic send_preset(input board_t b);
        int waited;
        preset = 1'b1;
        preset_board = b;
        @(posedge clk);
        #1;
        preset = 1'b0;
        wait_for_ready(waited);
    endtask

    task automatic send_move(input logic [3:0] key);
        int     waited;
        logic   is_key;
        is_key = (key == DIR_LEFT) || (key == DIR_UP) || (key == DIR_DOWN) || (key == DIR_RIGHT);
        dir = key;
        // nothing may move while the key is down
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #1;
            check_board("board while key held", board, last_exp_board);
            if (!is_key && draw_state == DRAW_ACTIVE && !input_ready) begin
                abort_run("input_ready dropped for a dir value that is not one-hot");
            end
        end
        dir = '0;
        wait_for_ready(waited);
    endtask

    task automatic run_pattern(input pattern_t p);
        goal = p.goal;
        case (p.cmd)
            "R": send_restart();
            "P": send_preset(p.preset);
            "M": send_move(p.key);
            default: abort_run("unknown command in the pattern file");
        endcase
        check_board("board", board, p.exp_board);
        check_score("score", score, p.exp_score);
        check_draw("draw_state", draw_state, p.exp_draw);
        last_exp_board = p.exp_board;
    endtask

    initial begin
        int waited;
        reset = 1'b1;
        restart = 1'b0;
        goal = tile_t'(11);
        dir = '0;
        preset = 1'b0;
        preset_board = '0;
        read_patterns();
        if (patterns.size() == 0) begin
            abort_run("the pattern file holds no commands");
        end
        timeout_limit = patterns.size() * CYCLES_PER_LINE + 100;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_for_ready(waited);
        if (waited != START_CYCLES) begin
            abort_run($sformatf("FAILED input_ready delay: got %h expected %h",
                waited, START_CYCLES));
        end
        // two start tiles in the top left corner
        last_exp_board = words_to_board(16'h1100, 16'h0000, 16'h0000, 16'h0000);
        check_board("board", board, last_exp_board);
        check_score("score", score, '0);
        check_draw("draw_state", draw_state, DRAW_ACTIVE);
        foreach (patterns[i]) begin
            run_pattern(patterns[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: rtl/board_orient.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module board_orient (
    input  control_pkg::dir_t move_dir,
    input  board_pkg::board_t board,
    output board_pkg::board_t moved_board,
    output logic [3:0]        move_points,
    output logic              move_changed
);
    import board_pkg::*;
    import control_pkg::*;

    localparam int GRID = `GAME_GRID;

    row_t [GRID-1:0] canon_rows;
    row_t [GRID-1:0] slid_rows;
    logic [1:0]      row_points [GRID];
    logic [GRID-1:0] row_changed;
    logic            dir_valid;

    always_comb begin
        case (move_dir)
            DIR_LEFT, DIR_UP, DIR_DOWN, DIR_RIGHT: dir_valid = 1'b1;
            default: dir_valid = 1'b0;
        endcase
    end

    // turn the board so every move becomes a slide to the left
    always_comb begin
        for (int k = 0; k < GRID; k++) begin
            for (int i = 0; i < GRID; i++) begin
                case (move_dir)
                    DIR_RIGHT: canon_rows[k][i] = board[k][GRID-1-i];
                    DIR_UP:    canon_rows[k][i] = board[i][k];
                    DIR_DOWN:  canon_rows[k][i] = board[GRID-1-i][k];
                    default:   canon_rows[k][i] = board[k][i];
                endcase
            end
        end
    end

    for (genvar k = 0; k < GRID; k++) begin : g_rows
        row_slide slide_i (
            .row_in  (canon_rows[k]),
            .row_out (slid_rows[k]),
            .points  (row_points[k]),
            .changed (row_changed[k])
        );
    end

    // inverse mapping back to board orientation
    always_comb begin
        moved_board = board;
        for (int k = 0; k < GRID; k++) begin
            for (int i = 0; i < GRID; i++) begin
                case (move_dir)
                    DIR_LEFT:  moved_board[k][i] = slid_rows[k][i];
                    DIR_RIGHT: moved_board[k][GRID-1-i] = slid_rows[k][i];
                    DIR_UP:    moved_board[i][k] = slid_rows[k][i];
                    DIR_DOWN:  moved_board[GRID-1-i][k] = slid_rows[k][i];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        move_points = '0;
        for (int k = 0; k < GRID; k++) begin
            move_points = move_points + 4'(row_points[k]);
        end
        // no valid direction scores nothing
        if (!dir_valid) begin
            move_points = '0;
        end
    end

    assign move_changed = dir_valid && (|row_changed);

endmodule

// File: rtl/board_pkg.sv
`include "game_defs.svh"

package board_pkg;

    // one cell, stored as the exponent of the tile value
    typedef logic [`GAME_TILE_BITS-1:0] tile_t;

    // index 0 is the canonical left end
    typedef tile_t [`GAME_GRID-1:0] row_t;

    // row 0 on top, column 0 on the left
    typedef row_t [`GAME_GRID-1:0] board_t;

    typedef logic [`GAME_SCORE_BITS-1:0] score_t;

    // row or column position
    typedef logic [$clog2(`GAME_GRID)-1:0] cell_idx_t;

endpackage

// File: rtl/board_status.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module board_status (
    input  board_pkg::board_t    board,
    input  board_pkg::tile_t     goal,
    output logic                 board_won,
    output logic                 board_lost,
    output board_pkg::cell_idx_t first_empty_row,
    output board_pkg::cell_idx_t first_empty_col
);
    import board_pkg::*;

    localparam int GRID = `GAME_GRID;

    logic has_empty;
    logic has_pair;

    always_comb begin
        board_won = 1'b0;
        has_empty = 1'b0;
        first_empty_row = '0;
        first_empty_col = '0;
        // scan backwards so the first empty cell in row-major order wins
        for (int r = GRID - 1; r >= 0; r--) begin
            for (int c = GRID - 1; c >= 0; c--) begin
                if (board[r][c] == goal) begin
                    board_won = 1'b1;
                end
                if (board[r][c] == '0) begin
                    has_empty = 1'b1;
                    first_empty_row = cell_idx_t'(r);
                    first_empty_col = cell_idx_t'(c);
                end
            end
        end
    end

    // any equal neighbour still allows a merge
    always_comb begin
        has_pair = 1'b0;
        for (int r = 0; r < GRID; r++) begin
            for (int c = 0; c < GRID - 1; c++) begin
                if (board[r][c] == board[r][c+1]) begin
                    has_pair = 1'b1;
                end
            end
        end
        for (int r = 0; r < GRID - 1; r++) begin
            for (int c = 0; c < GRID; c++) begin
                if (board[r][c] == board[r+1][c]) begin
                    has_pair = 1'b1;
                end
            end
        end
    end

    assign board_lost = !has_empty && !has_pair;

endmodule

// File: rtl/board_store.sv
`timescale 1ns/1ps

module board_store (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 do_clear,
    input  logic                 do_spawn,
    input  logic                 do_preset,
    input  logic                 do_move,
    input  board_pkg::board_t    preset_board,
    input  board_pkg::board_t    moved_board,
    input  logic [3:0]           move_points,
    input  board_pkg::cell_idx_t first_empty_row,
    input  board_pkg::cell_idx_t first_empty_col,
    output board_pkg::board_t    board,
    output board_pkg::score_t    score
);
    import board_pkg::*;

    // new tiles are always a 2
    localparam tile_t SPAWN_TILE = tile_t'(1);

    always_ff @(posedge clk) begin
        if (reset || do_clear) begin
            board <= '0;
            score <= '0;
        end else if (do_preset) begin
            // score stays as it is
            board <= preset_board;
        end else if (do_move) begin
            board <= moved_board;
            score <= score + score_t'(move_points);
        end else if (do_spawn) begin
            board[first_empty_row][first_empty_col] <= SPAWN_TILE;
        end
    end

endmodule

// File: rtl/control_pkg.sv
package control_pkg;

    // one-hot key codes, anything else is no move
    typedef enum logic [3:0] {
        DIR_NONE  = 4'b0000,
        DIR_LEFT  = 4'b0001,
        DIR_UP    = 4'b0010,
        DIR_DOWN  = 4'b0100,
        DIR_RIGHT = 4'b1000
    } dir_t;

    typedef enum logic [1:0] {
        DRAW_ACTIVE = 2'b00,
        DRAW_WIN    = 2'b01,
        DRAW_LOSE   = 2'b10
    } draw_state_t;

    typedef enum logic [2:0] {
        START,
        SPAWN,
        CHECK,
        WAIT_INPUT,
        RELEASE,
        MOVE,
        WIN,
        LOSE
    } phase_t;

endpackage

// File: rtl/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// side of the square board
`define GAME_GRID 4

// tile exponent width, 0 is an empty cell
`define GAME_TILE_BITS 4

// score counter width
`define GAME_SCORE_BITS 12

`endif

// File: rtl/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     restart,
    input  logic [3:0]               dir,
    input  logic                     preset,
    input  logic                     board_won,
    input  logic                     board_lost,
    input  logic                     move_changed,
    output control_pkg::dir_t        move_dir,
    output logic                     do_clear,
    output logic                     do_spawn,
    output logic                     do_preset,
    output logic                     do_move,
    output logic                     input_ready,
    output control_pkg::draw_state_t draw_state
);
    import control_pkg::*;

    phase_t phase;
    phase_t phase_next;
    // one more spawn pending after the first start tile
    logic   start_spawn;
    logic   dir_valid;

    always_comb begin
        case (dir)
            DIR_LEFT, DIR_UP, DIR_DOWN, DIR_RIGHT: dir_valid = 1'b1;
            default: dir_valid = 1'b0;
        endcase
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            START: phase_next = SPAWN;
            SPAWN: phase_next = start_spawn ? SPAWN : CHECK;
            CHECK: begin
                if (board_won) begin
                    phase_next = WIN;
                end else if (board_lost) begin
                    phase_next = LOSE;
                end else begin
                    phase_next = WAIT_INPUT;
                end
            end
            WAIT_INPUT: begin
                if (preset) begin
                    phase_next = CHECK;
                end else if (dir_valid) begin
                    phase_next = RELEASE;
                end
            end
            // move only once the key is let go
            RELEASE: begin
                if (dir == '0) begin
                    phase_next = MOVE;
                end
            end
            MOVE: phase_next = move_changed ? SPAWN : WAIT_INPUT;
            WIN: phase_next = WIN;
            LOSE: phase_next = LOSE;
            default: phase_next = START;
        endcase
        if (restart) begin
            phase_next = START;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= START;
            move_dir <= DIR_NONE;
            start_spawn <= 1'b0;
        end else begin
            phase <= phase_next;
            if (phase == START) begin
                start_spawn <= 1'b1;
            end else if (phase == SPAWN) begin
                start_spawn <= 1'b0;
            end
            // latch on press, preset takes precedence
            if (phase == WAIT_INPUT && dir_valid && !preset) begin
                move_dir <= dir_t'(dir);
            end
        end
    end

    assign do_clear = (phase == START);
    assign do_spawn = (phase == SPAWN);
    assign do_preset = (phase == WAIT_INPUT) && preset;
    assign do_move = (phase == MOVE);
    assign input_ready = (phase == WAIT_INPUT);

    always_comb begin
        case (phase)
            WIN: draw_state = DRAW_WIN;
            LOSE: draw_state = DRAW_LOSE;
            default: draw_state = DRAW_ACTIVE;
        endcase
    end

endmodule

// File: rtl/game_top.sv
`timescale 1ns/1ps

module game_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     restart,
    input  board_pkg::tile_t         goal,
    input  logic [3:0]               dir,
    input  logic                     preset,
    input  board_pkg::board_t        preset_board,
    output board_pkg::board_t        board,
    output board_pkg::score_t        score,
    output control_pkg::draw_state_t draw_state,
    output logic                     input_ready
);
    import board_pkg::*;
    import control_pkg::*;

    // sequencer strobes
    dir_t      move_dir;
    logic      do_clear;
    logic      do_spawn;
    logic      do_preset;
    logic      do_move;

    // slide results
    board_t    moved_board;
    logic [3:0] move_points;
    logic      move_changed;

    // board scan results
    logic      board_won;
    logic      board_lost;
    cell_idx_t first_empty_row;
    cell_idx_t first_empty_col;

    game_fsm fsm_i (
        .clk          (clk),
        .reset        (reset),
        .restart      (restart),
        .dir          (dir),
        .preset       (preset),
        .board_won    (board_won),
        .board_lost   (board_lost),
        .move_changed (move_changed),
        .move_dir     (move_dir),
        .do_clear     (do_clear),
        .do_spawn     (do_spawn),
        .do_preset    (do_preset),
        .do_move      (do_move),
        .input_ready  (input_ready),
        .draw_state   (draw_state)
    );

    board_store store_i (
        .clk             (clk),
        .reset           (reset),
        .do_clear        (do_clear),
        .do_spawn        (do_spawn),
        .do_preset       (do_preset),
        .do_move         (do_move),
        .preset_board    (preset_board),
        .moved_board     (moved_board),
        .move_points     (move_points),
        .first_empty_row (first_empty_row),
        .first_empty_col (first_empty_col),
        .board           (board),
        .score           (score)
    );

    board_status status_i (
        .board           (board),
        .goal            (goal),
        .board_won       (board_won),
        .board_lost      (board_lost),
        .first_empty_row (first_empty_row),
        .first_empty_col (first_empty_col)
    );

    board_orient orient_i (
        .move_dir     (move_dir),
        .board        (board),
        .moved_board  (moved_board),
        .move_points  (move_points),
        .move_changed (move_changed)
    );

endmodule

// File: rtl/row_slide.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module row_slide (
    input  board_pkg::row_t row_in,
    output board_pkg::row_t row_out,
    output logic [1:0]      points,
    output logic            changed
);
    import board_pkg::*;

    localparam int GRID = `GAME_GRID;

    // one spare slot on the right, always empty
    tile_t [GRID:0] compact;

    always_comb begin
        int  n;
        int  k;
        logic skip;

        // push non-empty tiles to the left, order kept
        compact = '0;
        n = 0;
        for (int i = 0; i < GRID; i++) begin
            if (row_in[i] != '0) begin
                compact[n] = row_in[i];
                n++;
            end
        end

        // merge equal neighbours from the left, once per tile
        row_out = '0;
        points = '0;
        k = 0;
        skip = 1'b0;
        for (int i = 0; i < GRID; i++) begin
            if (skip) begin
                skip = 1'b0;
            end else if (compact[i] != '0) begin
                if (compact[i] == compact[i+1]) begin
                    row_out[k] = compact[i] + tile_t'(1);
                    points = points + 2'd1;
                    skip = 1'b1;
                end else begin
                    row_out[k] = compact[i];
                end
                k++;
            end
        end
    end

    assign changed = (row_out != row_in);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the game testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module game_tb -f sim.f -o game_sim \
    && ./obj_dir/game_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+rtl
+incdir+bench
rtl/board_pkg.sv
rtl/control_pkg.sv
rtl/row_slide.sv
rtl/board_orient.sv
rtl/board_status.sv
rtl/board_store.sv
rtl/game_fsm.sv
rtl/game_top.sv
bench/game_tb.sv
